/* sources.f */
+incdir+verif
common/bram_bus_pkg.sv
bram/bram_bus_slave.sv
source/client_arbiter.sv
source/bus_master.sv
source/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_mem_model.svh */
// Testbench reference model: xorshift generator, reference memory, expected-read and range functions
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

logic [WORD_WIDTH-1:0] ref_mem [bit [ADDR_WIDTH-1:0]];   // Words written so far, by address

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

// Only the array index bits may be set
function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] a);
    return (a >> MEM_DEPTH_LOG2) == 0;
endfunction

function automatic logic [WORD_WIDTH-1:0] expected_read(input logic [ADDR_WIDTH-1:0] a);
    if (!addr_in_range(a) || !ref_mem.exists(a)) begin
        return '0;   // Out-of-range reads come back as zero
    end
    return ref_mem[a];
endfunction

function automatic void record_write(input logic [ADDR_WIDTH-1:0] a,
                                     input logic [WORD_WIDTH-1:0] d);
    ref_mem[a] = d;
endfunction

`endif

/* verif/tb_mem_subsystem.sv */
// Testbench for the memory subsystem: clock, reset, client drivers, checker, watchdog, report
`timescale 1ns/1ps

module tb_mem_subsystem
    import bram_bus_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int N_RANDOM       = 40;                        // Per client
    localparam int N_TRANS        = 3 + 8 + 2 * N_RANDOM + 3;
    localparam int TIMEOUT_CYCLES = N_TRANS * 20 + 50;
    localparam logic [31:0] SEED  = 32'h4d28;
    localparam logic [ADDR_WIDTH-1:0] P2_ADDR = 32'h0000_0123;

    logic                  itf;
    logic                  reset;
    logic                  req   [2];   // Index 0 is client a
    mem_op_t               op    [2];
    logic [ADDR_WIDTH-1:0] addr  [2];
    logic [WORD_WIDTH-1:0] wdata [2];
    logic                  ack   [2];
    logic [WORD_WIDTH-1:0] rdata [2];
    logic                  error;

    logic                  ack_prev [2];
    logic                  error_seen;
    logic [ADDR_WIDTH-1:0] written [$];   // In-range addresses with a completed write
    int                    ack_order [$];
    int                    checked;
    int                    check_errors;
    int                    seq_errors;

    `include "tb_mem_model.svh"

    mem_subsystem_top u_dut (
        .itf     (itf),
        .reset   (reset),
        .a_req   (req[0]),
        .a_op    (op[0]),
        .a_addr  (addr[0]),
        .a_wdata (wdata[0]),
        .a_ack   (ack[0]),
        .a_rdata (rdata[0]),
        .b_req   (req[1]),
        .b_op    (op[1]),
        .b_addr  (addr[1]),
        .b_wdata (wdata[1]),
        .b_ack   (ack[1]),
        .b_rdata (rdata[1]),
        .error   (error)
    );

    initial begin
        itf = 1'b0;
        forever #(CLK_PERIOD / 2) itf = ~itf;
    end

    // One four-phase request, returns once ack has dropped again
    task automatic run_request(input int c, input mem_op_t o,
                               input logic [ADDR_WIDTH-1:0] a, input logic [WORD_WIDTH-1:0] d);
        @(posedge itf);
        req[c]   <= 1'b1;
        op[c]    <= o;
        addr[c]  <= a;
        wdata[c] <= d;
        do @(posedge itf); while (!ack[c]);
        req[c] <= 1'b0;
        do @(posedge itf); while (ack[c]);
    endtask

    task automatic run_random_mix(input int c, input logic [31:0] seed);
        logic [31:0]           s;
        logic [ADDR_WIDTH-1:0] a;
        int                    idx;
        s = seed;
        repeat (N_RANDOM) begin
            s = xorshift32(s);
            if (s[0] || written.size() == 0) begin
                a = s[31:27] * 31;   // Small shared address set so words get overwritten
                run_request(c, op_write, a, {xorshift32(~s), s});
            end else begin
                idx = int'(s[23:8]) % written.size();
                run_request(c, op_read, written[idx], '0);
            end
        end
    endtask

    task automatic check_reply(input int c);
        logic [ADDR_WIDTH-1:0] a;
        logic [WORD_WIDTH-1:0] exp_word;
        a = addr[c];
        if (!addr_in_range(a)) begin
            error_seen = 1'b1;
        end
        if (op[c] == op_read) begin
            exp_word = expected_read(a);
            assert (rdata[c] === exp_word) else begin
                check_errors++;
                $display("MISMATCH %s at address %h: got %h expected %h",
                         c == 0 ? "a_rdata" : "b_rdata", a, rdata[c], exp_word);
            end
        end else if (addr_in_range(a)) begin
            record_write(a, wdata[c]);
            written.push_back(a);
        end
        assert (error === error_seen) else begin
            check_errors++;
            $display("MISMATCH error: got %h expected %h", error, error_seen);
        end
        ack_order.push_back(c);
        checked++;
    endtask

    // Checker samples each rising ack
    always @(posedge itf) begin
        if (reset) begin
            ack_prev[0] = 1'b0;
            ack_prev[1] = 1'b0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (ack[c] && !ack_prev[c]) begin
                    check_reply(c);
                end
                ack_prev[c] = ack[c];
            end
        end
    end

    initial begin
        int base;
        int first;
        int expect_first;
        reset = 1'b1;
        error_seen = 1'b0;
        checked = 0;
        check_errors = 0;
        seq_errors = 0;
        for (int c = 0; c < 2; c++) begin
            req[c]   = 1'b0;
            op[c]    = op_read;
            addr[c]  = '0;
            wdata[c] = '0;
        end
        repeat (RESET_CYCLES) @(posedge itf);
        reset <= 1'b0;

        repeat (5) begin   // Quiet outputs with no request
            @(posedge itf);
            assert (!ack[0] && !ack[1] && !error) else begin
                seq_errors++;
                $display("MISMATCH a_ack=%h b_ack=%h error=%h expected 0", ack[0], ack[1], error);
            end
        end

        run_request(0, op_write, P2_ADDR, 64'hdead_beef_0123_4567);
        run_request(1, op_read, P2_ADDR, '0);
        run_request(0, op_read, P2_ADDR, '0);

        expect_first = 0;
        for (int r = 0; r < 4; r++) begin
            base = ack_order.size();
            fork
                run_request(0, r < 2 ? op_write : op_read, 32'h0a0, {32'hc0de_0000 + r, 32'haaaa});
                run_request(1, r < 2 ? op_write : op_read, 32'h0b0, {32'hbeef_0000 + r, 32'hbbbb});
            join
            first = ack_order[base];
            assert (first == expect_first) else begin
                seq_errors++;
                $display("MISMATCH first_ack round %0d: got %h expected %h", r, first, expect_first);
            end
            expect_first ^= 1;   // Pointer flips on every contested grant
        end

        fork
            run_random_mix(0, SEED);
            run_random_mix(1, xorshift32(SEED) ^ 32'h0001_0000);
        join

        // Out-of-range write aliases P2_ADDR in the low bits
        run_request(0, op_write, P2_ADDR | 32'h0000_0400, 64'h5555_aaaa_5555_aaaa);
        run_request(0, op_read, P2_ADDR, '0);
        run_request(1, op_read, 32'h8000_0010, '0);
        repeat (3) @(posedge itf);
        assert (error === 1'b1) else begin
            seq_errors++;
            $display("MISMATCH error: got %h expected %h", error, 1'b1);
        end

        $display("Transactions checked: %0d, check errors: %0d, sequence errors: %0d",
                 checked, check_errors, seq_errors);
        if (check_errors == 0 && seq_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge itf);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Transactions checked: %0d, check errors: %0d, sequence errors: %0d",
                 checked, check_errors, seq_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

/* source/mem_subsystem_top.sv */
// Top level: client arbiter, bus master and memory slave
`timescale 1ns/1ps

module mem_subsystem_top
    import bram_bus_pkg::*;
(
    input  logic                  itf,
    input  logic                  reset,
    input  logic                  a_req,
    input  mem_op_t               a_op,
    input  logic [ADDR_WIDTH-1:0] a_addr,
    input  logic [WORD_WIDTH-1:0] a_wdata,
    output logic                  a_ack,
    output logic [WORD_WIDTH-1:0] a_rdata,
    input  logic                  b_req,
    input  mem_op_t               b_op,
    input  logic [ADDR_WIDTH-1:0] b_addr,
    input  logic [WORD_WIDTH-1:0] b_wdata,
    output logic                  b_ack,
    output logic [WORD_WIDTH-1:0] b_rdata,
    output logic                  error
);

    logic                  m_req;
    mem_op_t               m_op;
    logic [ADDR_WIDTH-1:0] m_addr;
    logic [WORD_WIDTH-1:0] m_wdata;
    logic                  m_ack;
    logic [WORD_WIDTH-1:0] m_rdata;

    // Multiplexed bus between master and memory
    logic                  read_en;
    logic                  write_en;
    logic                  address_on;
    logic                  data_on;
    logic [BUS_WIDTH-1:0]  bus_out;
    logic                  resp;
    logic [WORD_WIDTH-1:0] bus_in;

    client_arbiter u_arbiter (
        .itf     (itf),
        .reset   (reset),
        .a_req   (a_req),
        .b_req   (b_req),
        .a_op    (a_op),
        .b_op    (b_op),
        .a_addr  (a_addr),
        .b_addr  (b_addr),
        .a_wdata (a_wdata),
        .b_wdata (b_wdata),
        .a_ack   (a_ack),
        .b_ack   (b_ack),
        .a_rdata (a_rdata),
        .b_rdata (b_rdata),
        .m_req   (m_req),
        .m_op    (m_op),
        .m_addr  (m_addr),
        .m_wdata (m_wdata),
        .m_ack   (m_ack),
        .m_rdata (m_rdata)
    );

    bus_master u_master (
        .itf        (itf),
        .reset      (reset),
        .m_req      (m_req),
        .m_op       (m_op),
        .m_addr     (m_addr),
        .m_wdata    (m_wdata),
        .m_ack      (m_ack),
        .m_rdata    (m_rdata),
        .read_en    (read_en),
        .write_en   (write_en),
        .address_on (address_on),
        .data_on    (data_on),
        .bus_out    (bus_out),
        .resp       (resp),
        .bus_in     (bus_in)
    );

    bram_bus_slave u_slave (
        .itf        (itf),
        .reset      (reset),
        .read_en    (read_en),
        .write_en   (write_en),
        .address_on (address_on),
        .data_on    (data_on),
        .bus_out    (bus_out),
        .resp       (resp),
        .bus_in     (bus_in),
        .error      (error)
    );

endmodule

/* source/bus_master.sv */
// Bus master: splits one granted request into address and data beats, collects the read word
`timescale 1ns/1ps

module bus_master
    import bram_bus_pkg::*;
(
    input  logic                  itf,
    input  logic                  reset,
    input  logic                  m_req,
    input  mem_op_t               m_op,
    input  logic [ADDR_WIDTH-1:0] m_addr,
    input  logic [WORD_WIDTH-1:0] m_wdata,
    output logic                  m_ack,
    output logic [WORD_WIDTH-1:0] m_rdata,
    output logic                  read_en,
    output logic                  write_en,
    output logic                  address_on,
    output logic                  data_on,
    output logic [BUS_WIDTH-1:0]  bus_out,
    input  logic                  resp,
    input  logic [WORD_WIDTH-1:0] bus_in
);

    master_state_t         state;
    master_state_t         next_state;
    mem_op_t               op_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [WORD_WIDTH-1:0] wdata_q;
    logic                  seen_first;   // Read gets two respond cycles
    logic                  final_resp;
    logic                  busy;

    assign final_resp = (state == ms_wait) && resp && ((op_q == op_write) || seen_first);

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= ms_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ms_idle: begin
                if (m_req) begin
                    next_state = ms_address;
                end
            end
            ms_address: begin
                if (resp) begin
                    next_state = (op_q == op_write) ? ms_data_lo : ms_wait;
                end
            end
            ms_data_lo: begin
                if (resp) begin
                    next_state = ms_data_hi;
                end
            end
            ms_data_hi: begin
                if (resp) begin
                    next_state = ms_wait;
                end
            end
            ms_wait: begin
                if (final_resp) begin
                    next_state = ms_ack;
                end
            end
            ms_ack: begin
                if (!m_req) begin   // Four-phase return to zero
                    next_state = ms_idle;
                end
            end
            default: begin
                next_state = ms_idle;
            end
        endcase
    end

    // Request fields are taken once per transaction
    always_ff @(posedge itf) begin
        if (state == ms_idle && m_req) begin
            op_q    <= m_op;
            addr_q  <= m_addr;
            wdata_q <= m_wdata;
        end
        if (final_resp) begin
            m_rdata <= bus_in;
        end
    end

    always_ff @(posedge itf) begin
        if (reset) begin
            seen_first <= 1'b0;
        end else if (state == ms_wait && resp) begin
            seen_first <= 1'b1;
        end else if (state == ms_idle) begin
            seen_first <= 1'b0;
        end
    end

    assign busy       = (state != ms_idle) && (state != ms_ack);
    assign read_en    = busy && (op_q == op_read);
    assign write_en   = busy && (op_q == op_write);
    assign address_on = (state == ms_address);
    assign data_on    = (state == ms_data_lo) || (state == ms_data_hi);
    assign m_ack      = (state == ms_ack);

    always_comb begin
        case (state)
            ms_address: bus_out = addr_q;
            ms_data_lo: bus_out = wdata_q[BUS_WIDTH-1:0];
            ms_data_hi: bus_out = wdata_q[WORD_WIDTH-1:BUS_WIDTH];
            default:    bus_out = '0;
        endcase
    end

    assert property (@(posedge itf) disable iff (reset) !(address_on && data_on));

endmodule

/* source/client_arbiter.sv */
// Round-robin arbiter for two four-phase clients, steering request and reply fields
`timescale 1ns/1ps

module client_arbiter
    import bram_bus_pkg::*;
(
    input  logic                  itf,
    input  logic                  reset,
    input  logic                  a_req,
    input  logic                  b_req,
    input  mem_op_t               a_op,
    input  mem_op_t               b_op,
    input  logic [ADDR_WIDTH-1:0] a_addr,
    input  logic [ADDR_WIDTH-1:0] b_addr,
    input  logic [WORD_WIDTH-1:0] a_wdata,
    input  logic [WORD_WIDTH-1:0] b_wdata,
    output logic                  a_ack,
    output logic                  b_ack,
    output logic [WORD_WIDTH-1:0] a_rdata,
    output logic [WORD_WIDTH-1:0] b_rdata,
    output logic                  m_req,
    output mem_op_t               m_op,
    output logic [ADDR_WIDTH-1:0] m_addr,
    output logic [WORD_WIDTH-1:0] m_wdata,
    input  logic                  m_ack,
    input  logic [WORD_WIDTH-1:0] m_rdata
);

    logic busy;
    logic grant_b;     // 0 selects client a
    logic prefer_b;    // Round-robin pointer
    logic m_ack_q;

    always_ff @(posedge itf) begin
        if (reset) begin
            busy     <= 1'b0;
            grant_b  <= 1'b0;
            prefer_b <= 1'b0;
            m_ack_q  <= 1'b0;
        end else begin
            m_ack_q <= m_ack;
            if (!busy) begin
                if (a_req && b_req) begin
                    busy     <= 1'b1;
                    grant_b  <= prefer_b;
                    prefer_b <= !prefer_b;   // Flip only on a contested grant
                end else if (a_req || b_req) begin
                    busy    <= 1'b1;
                    grant_b <= b_req;
                end
            end else if (m_ack_q && !m_ack) begin
                busy <= 1'b0;   // Release on falling m_ack
            end
        end
    end

    assign m_req   = busy && (grant_b ? b_req : a_req);
    assign m_op    = grant_b ? b_op : a_op;
    assign m_addr  = grant_b ? b_addr : a_addr;
    assign m_wdata = grant_b ? b_wdata : a_wdata;

    assign a_ack   = busy && !grant_b && m_ack;
    assign b_ack   = busy && grant_b && m_ack;
    assign a_rdata = (busy && !grant_b) ? m_rdata : '0;
    assign b_rdata = (busy && grant_b) ? m_rdata : '0;

    assert property (@(posedge itf) disable iff (reset) !(a_ack && b_ack));

endmodule

/* bram/bram_bus_slave.sv */
// Memory slave: bus beat FSM, address and data capture, word array, sticky error flag
`timescale 1ns/1ps

module bram_bus_slave
    import bram_bus_pkg::*;
(
    input  logic                  itf,
    input  logic                  reset,
    input  logic                  read_en,
    input  logic                  write_en,
    input  logic                  address_on,
    input  logic                  data_on,
    input  logic [BUS_WIDTH-1:0]  bus_out,
    output logic                  resp,
    output logic [WORD_WIDTH-1:0] bus_in,
    output logic                  error
);

    logic [WORD_WIDTH-1:0] mem [0:(2**MEM_DEPTH_LOG2)-1];

    slave_state_t          state;
    slave_state_t          next_state;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [WORD_WIDTH-1:0] wdata_q;
    logic                  store_addr;
    logic                  store_lo;
    logic                  store_hi;
    logic                  load_read;
    logic                  commit;
    logic                  in_range;

    // Upper address bits beyond the array index must be clear
    assign in_range = (addr_q[ADDR_WIDTH-1:MEM_DEPTH_LOG2] == '0);

    always_ff @(posedge itf) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        store_addr = 1'b0;
        store_lo   = 1'b0;
        store_hi   = 1'b0;
        load_read  = 1'b0;
        commit     = 1'b0;
        resp       = 1'b0;
        case (state)
            st_idle: begin
                if (read_en || write_en) begin
                    next_state = st_address;
                end
            end
            st_address: begin
                if (address_on) begin
                    store_addr = 1'b1;
                    resp       = 1'b1;
                    if (write_en) begin
                        next_state = st_data_lo;
                    end else begin
                        next_state = st_read_respond;
                    end
                end
            end
            st_data_lo: begin
                if (data_on) begin
                    store_lo   = 1'b1;
                    resp       = 1'b1;
                    next_state = st_data_hi;
                end
            end
            st_data_hi: begin
                if (data_on) begin
                    store_hi   = 1'b1;
                    resp       = 1'b1;
                    next_state = st_respond;
                end
            end
            st_read_respond: begin
                resp       = 1'b1;
                load_read  = 1'b1;   // Word lands on bus_in for st_respond
                next_state = st_respond;
            end
            st_respond: begin
                resp       = 1'b1;
                commit     = 1'b1;
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // Address and write data halves
    always_ff @(posedge itf) begin
        if (store_addr) begin
            addr_q <= bus_out;
        end
        if (store_lo) begin
            wdata_q[BUS_WIDTH-1:0] <= bus_out;
        end
        if (store_hi) begin
            wdata_q[WORD_WIDTH-1:BUS_WIDTH] <= bus_out;
        end
    end

    always_ff @(posedge itf) begin
        if (commit && write_en && in_range) begin
            mem[addr_q[MEM_DEPTH_LOG2-1:0]] <= wdata_q;
        end
        if (load_read) begin
            bus_in <= in_range ? mem[addr_q[MEM_DEPTH_LOG2-1:0]] : '0;
        end
    end

    // Sticky until reset
    always_ff @(posedge itf) begin
        if (reset) begin
            error <= 1'b0;
        end else if (commit && !in_range) begin
            error <= 1'b1;
        end
    end

    // The requester never asks for both operations at once
    assert property (@(posedge itf) disable iff (reset) !(read_en && write_en));

    assert property (@(posedge itf) disable iff (reset) (state == st_idle) |-> !resp);

endmodule

/* common/bram_bus_pkg.sv */
// Shared widths, memory depth, opcode and state machine encodings
package bram_bus_pkg;

    localparam int WORD_WIDTH     = 64;   // Memory word
    localparam int BUS_WIDTH      = 32;   // Multiplexed address/data bus
    localparam int ADDR_WIDTH     = 32;   // Word address
    localparam int MEM_DEPTH_LOG2 = 10;   // Index bits of the word array

    // Client request opcode
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // Memory side of the bus
    typedef enum logic [2:0] {
        st_idle         = 3'd0,
        st_address      = 3'd1,
        st_data_lo      = 3'd2,
        st_data_hi      = 3'd3,
        st_read_respond = 3'd4,
        st_respond      = 3'd5
    } slave_state_t;

    // Requester side of the bus
    typedef enum logic [2:0] {
        ms_idle    = 3'd0,
        ms_address = 3'd1,
        ms_data_lo = 3'd2,
        ms_data_hi = 3'd3,
        ms_wait    = 3'd4,
        ms_ack     = 3'd5
    } master_state_t;

endpackage
